// ==== project.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/dmem_if.sv
verilog/mem_stage.sv
verilog/data_mem.sv
verilog/wb_regfile.sv
verilog/mem_wb_top.sv
dv/tb_clk_gen.sv
dv/mem_wb_checker.sv
dv/mem_wb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory/write-back testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=mem_wb_sim

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module mem_wb_tb -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== dv/mem_wb_tb.sv ====
////////////////////////////////////////
// Testbench for the memory and write-back
// top level with register and memory models
////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_defs.svh"

module mem_wb_tb import rv_pkg::*; ();

	// Instruction counts per test, a register sweep costs about 34 cycles
	localparam int N_ALU = 12;
	localparam int N_JUMP = 8;
	localparam int N_MEM = 48;
	localparam int N_MIX = 16;
	localparam int N_ZERO = 8;
	localparam int N_TESTS = 5;
	localparam int SWEEP_CYCLES = 34;
	localparam int LIMIT = (N_ALU + N_JUMP + N_MEM + N_MIX + N_ZERO) * (`DMEM_WAIT + 4) +
		N_TESTS * SWEEP_CYCLES + 100;

	logic     clk;
	logic     rst_n;
	logic     i_valid;
	word_t    i_result;
	word_t    i_data_store;
	word_t    i_pc;
	opcode_t  i_opcode;
	func3_t   i_func3;
	reg_idx_t i_rd;
	reg_idx_t i_dbg_raddr;
	logic     o_stall;
	word_t    o_dbg_rdata;

	// Expected register file and byte-wide image of the data memory
	word_t       reg_model [32];
	logic [7:0]  ref_mem [1024];
	logic [7:0]  words [8];
	logic [31:0] lfsr_q;
	int          errors;
	int          tests_failed;
	int          cycles;

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mem_wb_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_valid      (i_valid),
		.i_result     (i_result),
		.i_data_store (i_data_store),
		.i_pc         (i_pc),
		.i_opcode     (i_opcode),
		.i_func3      (i_func3),
		.i_rd         (i_rd),
		.i_dbg_raddr  (i_dbg_raddr),
		.o_stall      (o_stall),
		.o_dbg_rdata  (o_dbg_rdata)
	);

	// Galois LFSR, one step per bit handed out, newest bit lands in bit 0
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        bit_out;
		val = '0;
		for (int k = 0; k < n; k++)
		begin
			bit_out = lfsr_q[0];
			lfsr_q = lfsr_q >> 1;
			if (bit_out)
				lfsr_q = lfsr_q ^ 32'h80200003;
			val = {val[30:0], bit_out};
		end
		return val;
	endfunction

	// Present one instruction and hold it until the stage lets it go
	// Only a load may stall, for its wait states plus the accept cycle
	task automatic send(input opcode_t op, input func3_t f3, input word_t result,
		input word_t data, input word_t pc, input reg_idx_t rd);
		int stalls;
		int exp_stalls;
		exp_stalls = (op == `RV_OP_LOAD) ? `DMEM_WAIT + 1 : 0;
		stalls = 0;
		@(posedge clk);
		i_valid      <= 1'b1;
		i_opcode     <= op;
		i_func3      <= f3;
		i_result     <= result;
		i_data_store <= data;
		i_pc         <= pc;
		i_rd         <= rd;
		@(negedge clk);
		while (o_stall)
		begin
			stalls++;
			@(negedge clk);
		end
		// The next rising edge consumes the instruction
		assert (stalls == exp_stalls)
		else
		begin
			$display("ERROR: o_stall cycles for opcode 0x%h expected 0x%h actual 0x%h",
				op, exp_stalls, stalls);
			errors++;
		end
	endtask

	task automatic alu_op(input reg_idx_t rd);
		opcode_t op;
		word_t   value;
		case (int'(rand_bits(2)))
			0:       op = `RV_OP_ALU;
			1:       op = `RV_OP_ALUI;
			default: op = `RV_OP_LUI;
		endcase
		value = rand_bits(32);
		send(op, func3_t'(rand_bits(3)), value, rand_bits(32), rand_bits(32), rd);
		if (rd != 5'd0)
			reg_model[rd] = value;
	endtask

	// Both jump kinds link the address of the following instruction
	task automatic jump_op(input reg_idx_t rd);
		opcode_t op;
		word_t   pc;
		op = rand_bits(1) ? `RV_OP_JAL : `RV_OP_JALR;
		pc = rand_bits(32);
		send(op, func3_t'(rand_bits(3)), rand_bits(32), rand_bits(32), pc, rd);
		if (rd != 5'd0)
			reg_model[rd] = pc + 32'd4;
	endtask

	// Width 0 is a byte, 1 a half and anything else a word
	task automatic store_op(input int slot, input int width);
		func3_t     f3;
		logic [1:0] off;
		word_t      hi;
		word_t      addr;
		word_t      data;
		int         nbytes;
		int         idx;
		data = rand_bits(32);
		hi = rand_bits(22);
		case (width)
			0:
			begin
				f3 = `RV_F3_B;
				off = 2'(rand_bits(2));
				nbytes = 1;
			end
			1:
			begin
				f3 = `RV_F3_H;
				off = 2'(rand_bits(2)) & 2'b10;
				nbytes = 2;
			end
			default:
			begin
				f3 = `RV_F3_W;
				off = 2'b00;
				nbytes = 4;
			end
		endcase
		// High address bits are random and alias onto the same word
		addr = {hi[21:0], words[slot], off};
		idx = int'(addr[9:0]);
		send(`RV_OP_STORE, f3, addr, data, rand_bits(32), reg_idx_t'(rand_bits(5)));
		for (int b = 0; b < nbytes; b++)
			ref_mem[idx + b] = data[8*b +: 8];
	endtask

	task automatic load_op(input int slot, input reg_idx_t rd);
		func3_t     f3;
		logic [1:0] off;
		word_t      hi;
		word_t      addr;
		word_t      exp_val;
		int         idx;
		hi = rand_bits(22);
		off = 2'(rand_bits(2));
		case (int'(rand_bits(3)) % 5)
			0:       f3 = `RV_F3_B;
			1:       f3 = `RV_F3_BU;
			2:       f3 = `RV_F3_H;
			3:       f3 = `RV_F3_HU;
			default: f3 = `RV_F3_W;
		endcase
		// Halves sit on even bytes and words on byte 0
		if (f3 == `RV_F3_H || f3 == `RV_F3_HU)
			off = off & 2'b10;
		else if (f3 == `RV_F3_W)
			off = 2'b00;
		addr = {hi[21:0], words[slot], off};
		idx = int'(addr[9:0]);
		case (f3)
			`RV_F3_B:  exp_val = {{24{ref_mem[idx][7]}}, ref_mem[idx]};
			`RV_F3_BU: exp_val = {24'd0, ref_mem[idx]};
			`RV_F3_H:  exp_val = {{16{ref_mem[idx+1][7]}}, ref_mem[idx+1], ref_mem[idx]};
			`RV_F3_HU: exp_val = {16'd0, ref_mem[idx+1], ref_mem[idx]};
			default:   exp_val = {ref_mem[idx+3], ref_mem[idx+2], ref_mem[idx+1], ref_mem[idx]};
		endcase
		send(`RV_OP_LOAD, f3, addr, rand_bits(32), rand_bits(32), rd);
		if (rd != 5'd0)
			reg_model[rd] = exp_val;
	endtask

	// Drop valid, let write-back land, then read every register through the debug port
	task automatic check_regs();
		@(posedge clk);
		i_valid <= 1'b0;
		for (int r = 0; r < 32; r++)
		begin
			@(posedge clk);
			i_dbg_raddr <= reg_idx_t'(r);
			@(negedge clk);
			assert (o_dbg_rdata === reg_model[r])
			else
			begin
				$display("ERROR: o_dbg_rdata x%0d expected 0x%h actual 0x%h",
					r, reg_model[r], o_dbg_rdata);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d checks failed", name, errors - err_before);
			tests_failed++;
		end
	endtask

	// Ends a run that stops making progress
	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		int base;
		lfsr_q = 32'd4598;
		errors = 0;
		tests_failed = 0;
		i_valid = 1'b0;
		i_result = '0;
		i_data_store = '0;
		i_pc = '0;
		i_opcode = '0;
		i_func3 = '0;
		i_rd = '0;
		i_dbg_raddr = '0;
		for (int r = 0; r < 32; r++)
			reg_model[r] = '0;
		@(posedge rst_n);
		repeat (2) @(posedge clk);

		// ALU and LUI results into nonzero registers
		base = errors;
		for (int n = 0; n < N_ALU; n++)
			alu_op(reg_idx_t'(1 + rand_bits(5) % 31));
		check_regs();
		finish_test("alu_lui", base);

		base = errors;
		for (int n = 0; n < N_JUMP; n++)
			jump_op(reg_idx_t'(1 + rand_bits(5) % 31));
		check_regs();
		finish_test("jump_link", base);

		// Fill eight words first so every later load reads known bytes
		base = errors;
		for (int s = 0; s < 8; s++)
		begin
			words[s] = 8'(rand_bits(8));
			store_op(s, 2);
		end
		for (int n = 0; n < 16; n++)
			store_op(int'(rand_bits(3)), int'(rand_bits(2)) % 3);
		for (int n = 0; n < 24; n++)
			load_op(int'(rand_bits(3)), reg_idx_t'(rand_bits(5)));
		check_regs();
		finish_test("load_store", base);

		// Back-to-back mix where stall counts are checked per instruction
		base = errors;
		for (int n = 0; n < N_MIX; n++)
		begin
			case (int'(rand_bits(2)))
				0:       alu_op(reg_idx_t'(rand_bits(5)));
				1:       store_op(int'(rand_bits(3)), int'(rand_bits(2)) % 3);
				2:       load_op(int'(rand_bits(3)), reg_idx_t'(rand_bits(5)));
				default: jump_op(reg_idx_t'(rand_bits(5)));
			endcase
		end
		check_regs();
		finish_test("stall_mix", base);

		// Everything aimed at x0, plus stores that name a real rd
		base = errors;
		for (int n = 0; n < 2; n++)
		begin
			alu_op(5'd0);
			load_op(int'(rand_bits(3)), 5'd0);
			store_op(int'(rand_bits(3)), int'(rand_bits(2)) % 3);
			jump_op(5'd0);
		end
		check_regs();
		finish_test("x0_and_stores", base);

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			N_TESTS, tests_failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== dv/mem_wb_checker.sv ====
////////////////////////////////////////
// Protocol checker for the memory and
// write-back top level
////////////////////////////////////////

`timescale 1ns/10ps

module mem_wb_checker import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      o_stall,
	input  logic      req,
	input  logic      ack,
	input  reg_idx_t  i_dbg_raddr,
	input  word_t     o_dbg_rdata
);

	// Nothing can be pending in the first cycle out of reset
	stall_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !o_stall)
		else $error("o_stall is high in the first cycle after reset");

	// The memory only accepts what the stage actually requests
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) ack |-> req)
		else $error("data memory ack seen without a pending req");

	// x0 is hardwired, so the debug port must show zero for it
	x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(i_dbg_raddr == 5'd0) |-> (o_dbg_rdata == '0))
		else $error("register x0 read back a nonzero value");

endmodule

// Attach the checker to every instance of the top level
bind mem_wb_top mem_wb_checker u_checker (
	.clk         (clk),
	.rst_n       (rst_n),
	.o_stall     (o_stall),
	.req         (u_dmem_if.req),
	.ack         (u_dmem_if.ack),
	.i_dbg_raddr (i_dbg_raddr),
	.o_dbg_rdata (o_dbg_rdata)
);

// ==== dv/tb_clk_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset
// 4 ns clock, reset low for 2 cycles
////////////////////////////////////////

`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// Free-running clock with a 2 ns half period
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset is released on a rising edge after two full cycles
	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== verilog/mem_wb_top.sv ====
////////////////////////////////////////
// Memory and write-back top level
// Memory stage, data memory and register
// file with plain pipeline ports
////////////////////////////////////////

`timescale 1ns/10ps

module mem_wb_top import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_valid,
	input  word_t     i_result,
	input  word_t     i_data_store,
	input  word_t     i_pc,
	input  opcode_t   i_opcode,
	input  func3_t    i_func3,
	input  reg_idx_t  i_rd,
	input  reg_idx_t  i_dbg_raddr,
	output logic      o_stall,
	output word_t     o_dbg_rdata
);

	// Write-back register contents toward the register file
	logic     wb_we;
	reg_idx_t wb_rd;
	word_t    wb_data;

	// Bus between the memory stage and the data memory
	dmem_if u_dmem_if ();

	mem_stage u_mem_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_valid      (i_valid),
		.i_result     (i_result),
		.i_data_store (i_data_store),
		.i_pc         (i_pc),
		.i_opcode     (i_opcode),
		.i_func3      (i_func3),
		.i_rd         (i_rd),
		.o_stall      (o_stall),
		.dmem         (u_dmem_if.stage),
		.o_wb_we      (wb_we),
		.o_wb_rd      (wb_rd),
		.o_wb_data    (wb_data)
	);

	data_mem u_data_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.dmem  (u_dmem_if.mem)
	);

	wb_regfile u_wb_regfile (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_we        (wb_we),
		.i_rd        (wb_rd),
		.i_wdata     (wb_data),
		.i_dbg_raddr (i_dbg_raddr),
		.o_dbg_rdata (o_dbg_rdata)
	);

endmodule

// ==== verilog/wb_regfile.sv ====
////////////////////////////////////////
// Write-back register file
// 32 x 32 registers with x0 tied to zero
// and a debug read port
////////////////////////////////////////

`timescale 1ns/10ps

module wb_regfile import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_we,
	input  reg_idx_t  i_rd,
	input  word_t     i_wdata,
	input  reg_idx_t  i_dbg_raddr,
	output word_t     o_dbg_rdata
);

	// Architectural registers, entry 0 is never written
	word_t regs [32];

	logic  wr_hit;

	// Writes to x0 are dropped here as well as in the memory stage
	assign wr_hit = i_we && (i_rd != 5'd0);

	// All registers start from zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_hit)
		begin
			regs[i_rd] <= i_wdata;
		end
	end

	// Debug port is combinational, so a written value shows right after the edge
	// x0 reads zero because it leaves reset at zero and is never written
	assign o_dbg_rdata = regs[i_dbg_raddr];

endmodule

// ==== verilog/data_mem.sv ====
////////////////////////////////////////
// Data memory
// Byte-strobed word RAM with a fixed
// number of wait states on reads
////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_defs.svh"

module data_mem import rv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	dmem_if.mem  dmem
);

	localparam int DEPTH = 1 << `DMEM_DEPTH_LOG2;

	// Wide enough to hold DMEM_WAIT, and at least one bit when it is zero
	localparam int CNT_W = $clog2(`DMEM_WAIT + 2);

	word_t                        mem [DEPTH];
	dmem_state_e                  state;
	logic [CNT_W-1:0]             wait_cnt;
	logic [`DMEM_DEPTH_LOG2-1:0]  word_idx;
	word_t                        rdata_q;

	// Word index drops the byte offset, high address bits alias
	assign word_idx = dmem.addr[`DMEM_DEPTH_LOG2+1:2];

	// Requests are only taken while idle, so one access is open at a time
	assign dmem.ack = (state == IDLE) && dmem.req;

	// Response pulse lines up with the registered read word
	assign dmem.rvalid = (state == RESP);
	assign dmem.rdata  = rdata_q;

	// Read sequencing
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= IDLE;
			wait_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Stores finish on the accept cycle and leave the FSM idle
					if (dmem.ack && !dmem.we)
					begin
						wait_cnt <= CNT_W'(`DMEM_WAIT);
						if (`DMEM_WAIT == 0)
							state <= RESP;
						else
							state <= WAIT;
					end
				end
				WAIT:
				begin
					// Last wait cycle when one count is left
					wait_cnt <= wait_cnt - 1'b1;
					if (wait_cnt == CNT_W'(1))
						state <= RESP;
				end
				RESP:
				begin
					state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Storage array, written per byte lane on an accepted store
	always_ff @(posedge clk)
	begin
		if (dmem.ack && dmem.we)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				if (dmem.strb[lane])
					mem[word_idx][lane*8 +: 8] <= dmem.wdata[lane*8 +: 8];
			end
		end
	end

	// The read word is taken at acceptance and held through the wait states
	always_ff @(posedge clk)
	begin
		if (dmem.ack && !dmem.we)
			rdata_q <= mem[word_idx];
	end

endmodule

// ==== verilog/mem_stage.sv ====
////////////////////////////////////////
// Memory stage
// Issues loads and stores, extends load
// data and fills the write-back register
////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_defs.svh"

module mem_stage import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_valid,
	input  word_t     i_result,
	input  word_t     i_data_store,
	input  word_t     i_pc,
	input  opcode_t   i_opcode,
	input  func3_t    i_func3,
	input  reg_idx_t  i_rd,
	output logic      o_stall,
	dmem_if.stage     dmem,
	output logic      o_wb_we,
	output reg_idx_t  o_wb_rd,
	output word_t     o_wb_data
);

	logic  is_load;
	logic  is_store;
	logic  is_jump;
	logic  is_alu;
	logic  done;
	logic  consume;
	strb_t strb_base;
	word_t load_lane;
	word_t load_ext;
	word_t wb_value;

	// Opcode decode, qualified by the incoming valid
	assign is_load  = i_valid && (i_opcode == `RV_OP_LOAD);
	assign is_store = i_valid && (i_opcode == `RV_OP_STORE);
	assign is_jump  = i_valid && ((i_opcode == `RV_OP_JAL) || (i_opcode == `RV_OP_JALR));
	assign is_alu   = i_valid && ((i_opcode == `RV_OP_ALU) || (i_opcode == `RV_OP_ALUI) ||
		(i_opcode == `RV_OP_LUI));

	// The effective address comes from the ALU result and stays put while stalled
	assign dmem.req  = is_load || is_store;
	assign dmem.we   = is_store;
	assign dmem.addr = i_result;

	// Store data moves up to the byte lane picked by the low address bits
	assign dmem.wdata = i_data_store << {i_result[1:0], 3'b000};

	always_comb
	begin
		if (i_func3 == `RV_F3_B)
			strb_base = 4'b0001;
		else if (i_func3 == `RV_F3_H)
			strb_base = 4'b0011;
		else
			strb_base = 4'b1111;
	end

	// Accesses are aligned, so the shifted mask never leaves the word
	assign dmem.strb = strb_base << i_result[1:0];

	// Bring the addressed lane of the read word down to bit 0
	assign load_lane = dmem.rdata >> {i_result[1:0], 3'b000};

	always_comb
	begin
		case (i_func3)
			`RV_F3_B:  load_ext = {{24{load_lane[7]}}, load_lane[7:0]};
			`RV_F3_H:  load_ext = {{16{load_lane[15]}}, load_lane[15:0]};
			`RV_F3_BU: load_ext = {24'd0, load_lane[7:0]};
			`RV_F3_HU: load_ext = {16'd0, load_lane[15:0]};
			`RV_F3_W:  load_ext = load_lane;
			default:   load_ext = load_lane;
		endcase
	end

	// A store is finished on its accept, a load on its response
	assign done = is_store ? dmem.ack : (is_load ? dmem.rvalid : 1'b1);

	// Upstream holds its inputs while a memory access is still open
	assign o_stall = dmem.req && !done;
	assign consume = i_valid && !o_stall;

	// Jumps link pc+4, loads return memory data, the rest pass the ALU result
	assign wb_value = is_load ? load_ext : (is_jump ? i_pc + 32'd4 : i_result);

	// Write enable only for instructions that name a real destination
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_wb_we <= 1'b0;
		else
			o_wb_we <= consume && (is_load || is_jump || is_alu) && (i_rd != 5'd0);
	end

	// Payload follows the enable and only changes on a consumed instruction
	always_ff @(posedge clk)
	begin
		if (consume)
		begin
			o_wb_rd   <= i_rd;
			o_wb_data <= wb_value;
		end
	end

endmodule

// ==== verilog/dmem_if.sv ====
////////////////////////////////////////
// Data memory bus
// Request from the memory stage, accept
// and read response from the memory
////////////////////////////////////////

`timescale 1ns/10ps

interface dmem_if import rv_pkg::*; ();

	// Request side, held stable while req is high
	logic  req;
	logic  we;
	word_t addr;
	word_t wdata;
	strb_t strb;

	// One-cycle accept pulse, only given when the memory is idle
	logic  ack;

	// One-cycle read response, DMEM_WAIT+1 cycles after ack
	logic  rvalid;
	word_t rdata;

	modport stage (
		output req, we, addr, wdata, strb,
		input  ack, rvalid, rdata
	);

	modport mem (
		input  req, we, addr, wdata, strb,
		output ack, rvalid, rdata
	);

endinterface

// ==== verilog/rv_pkg.sv ====
////////////////////////////////////////
// RV32I shared types
// Word, index and field vectors plus the
// data memory FSM states
////////////////////////////////////////

package rv_pkg;

	// Data or address word
	typedef logic [31:0] word_t;

	// Register file index
	typedef logic [4:0]  reg_idx_t;

	// Instruction fields the memory stage decodes
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  func3_t;

	// One bit per byte lane of a word
	typedef logic [3:0]  strb_t;

	// Data memory sequencing for reads
	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		RESP
	} dmem_state_e;

endpackage

// ==== include/rv_defs.svh ====
////////////////////////////////////////
// RV32I memory/write-back definitions
// Opcodes, load/store widths and data
// memory sizing
////////////////////////////////////////

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Major opcodes the memory stage tells apart
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_ALU    7'b0110011
`define RV_OP_ALUI   7'b0010011
`define RV_OP_LUI    7'b0110111

// Width codes in func3 for loads and stores
`define RV_F3_B      3'b000
`define RV_F3_H      3'b001
`define RV_F3_W      3'b010
`define RV_F3_BU     3'b100
`define RV_F3_HU     3'b101

// Data memory holds 2**8 words of 32 bits
`define DMEM_DEPTH_LOG2  8

// Cycles between acceptance of a load and the start of its response
`define DMEM_WAIT        2

`endif
